// ==== alu/exec_alu.sv ====
// Fixed-point ALU. All operations finish in the first stage, the remaining
// stages only carry the result. Compares leave a flag, not a mask.

`timescale 1ns/100ps
`default_nettype none

`include "exec_defs.svh"

module exec_alu (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire exec_data_pkg::issue_t   issue,
    output exec_data_pkg::alu_out_t      alu_out
);

    exec_data_pkg::alu_out_t pipe [`EXEC_ALU_DEPTH];

    exec_data_pkg::data_t a;
    exec_data_pkg::data_t b;
    exec_data_pkg::data_t bit_mask;
    exec_data_pkg::data_t result;
    logic [4:0]           bit_idx;

    function automatic exec_data_pkg::data_t popcount(input exec_data_pkg::data_t value);
        exec_data_pkg::data_t count;
        count = '0;
        for (int i = 0; i < `EXEC_DATA_WIDTH; i++) begin
            count = count + exec_data_pkg::data_t'(value[i]);
        end
        return count;
    endfunction

    assign a        = issue.operand_a;
    assign b        = issue.operand_b;
    assign bit_idx  = b[4:0];
    assign bit_mask = exec_data_pkg::data_t'(1) << bit_idx;

    always_comb begin
        case (issue.opcode)
            exec_isa_pkg::ADD:    result = a + b;
            exec_isa_pkg::SUB:    result = a - b;
            // Only the low half of the product is kept
            exec_isa_pkg::MUL:    result = a * b;
            exec_isa_pkg::LAND:   result = a & b;
            exec_isa_pkg::LOR:    result = a | b;
            exec_isa_pkg::LNOT:   result = ~a;
            exec_isa_pkg::SATP:   result = ($signed(a) < $signed(b)) ? a : b;
            exec_isa_pkg::SATN:   result = ($signed(a) > $signed(b)) ? a : b;
            exec_isa_pkg::ABS:    result = a[`EXEC_DATA_WIDTH-1] ? ('0 - a) : a;
            exec_isa_pkg::POPCNT: result = popcount(a);
            exec_isa_pkg::BSET:   result = a | bit_mask;
            exec_isa_pkg::BCLR:   result = a & ~bit_mask;
            exec_isa_pkg::BINV:   result = a ^ bit_mask;
            exec_isa_pkg::BSEL:   result = exec_data_pkg::data_t'(a[bit_idx]);
            exec_isa_pkg::LDC:    result = b;
            // Flag only, writeback widens it into a mask
            exec_isa_pkg::BGT:    result = exec_data_pkg::data_t'($signed(a) > $signed(b));
            exec_isa_pkg::BLE:    result = exec_data_pkg::data_t'($signed(a) <= $signed(b));
            exec_isa_pkg::BEQ:    result = exec_data_pkg::data_t'(a == b);
            exec_isa_pkg::BNE:    result = exec_data_pkg::data_t'(a != b);
            default:              result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        pipe[0].dest <= issue.dest;
        pipe[0].data <= result;
        for (int i = 1; i < `EXEC_ALU_DEPTH; i++) begin
            pipe[i].dest <= pipe[i-1].dest;
            pipe[i].data <= pipe[i-1].data;
        end
        if (!rst_n) begin
            for (int i = 0; i < `EXEC_ALU_DEPTH; i++) begin
                pipe[i].valid <= 1'b0;
            end
        end else begin
            pipe[0].valid <= issue.valid;
            for (int i = 1; i < `EXEC_ALU_DEPTH; i++) begin
                pipe[i].valid <= pipe[i-1].valid;
            end
        end
    end

    assign alu_out = pipe[`EXEC_ALU_DEPTH-1];

    // The writeback delay line relies on this exact latency
    alu_latency: assert property (
        @(posedge clock) disable iff (!rst_n)
        alu_out.valid == $past(issue.valid, `EXEC_ALU_DEPTH)
    ) else $error("ALU output valid out of step with issue");

endmodule

`default_nettype wire

// ==== common/exec_data_pkg.sv ====
// Data types and stage words of the execute path. Each stage word carries
// its own valid bit; there is no back-pressure anywhere.

`default_nettype none

`include "exec_defs.svh"

package exec_data_pkg;

    typedef logic [`EXEC_DATA_WIDTH-1:0]     data_t;
    typedef logic [`EXEC_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Immediate field of an instruction, sign extended for LDC
    typedef logic [15:0] imm_t;

    // Word leaving the issue stage
    // For LDC operand_b already holds the extended immediate
    typedef struct packed {
        logic                   valid;
        exec_isa_pkg::opcode_t  opcode;
        reg_addr_t              dest;
        data_t                  operand_a;
        data_t                  operand_b;
        imm_t                   imm;
    } issue_t;

    // Raw ALU result, compares leave only a flag in the low byte
    typedef struct packed {
        logic       valid;
        reg_addr_t  dest;
        data_t      data;
    } alu_out_t;

    // Final result, written to the register file and the result ports
    typedef struct packed {
        logic       valid;
        reg_addr_t  dest;
        data_t      data;
    } writeback_t;

endpackage

`default_nettype wire

// ==== common/exec_defs.svh ====
// Global sizes of the execute path. Modules take no parameters, so a change
// here applies to every block at once.

`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Width of a data word and of every register
`define EXEC_DATA_WIDTH 32

// Number of registers in the register file
`define EXEC_REG_COUNT 16

// Width of a register number, must cover EXEC_REG_COUNT
`define EXEC_REG_ADDR_WIDTH 4

// Register stages in the ALU pipeline
// The writeback opcode delay line follows this value
`define EXEC_ALU_DEPTH 3

`endif

// ==== common/exec_isa_pkg.sv ====
// Instruction set encoding. Codes 20 to 31 are undefined and are
// dropped at writeback without producing a result.

`default_nettype none

package exec_isa_pkg;

    // Raw opcode field as it appears in an instruction
    typedef logic [4:0] opcode_word_t;

    typedef enum opcode_word_t {
        NOP    = 5'd0,
        ADD    = 5'd1,
        SUB    = 5'd2,
        MUL    = 5'd3,
        LAND   = 5'd4,
        LOR    = 5'd5,
        LNOT   = 5'd6,
        SATP   = 5'd7,
        SATN   = 5'd8,
        ABS    = 5'd9,
        POPCNT = 5'd10,
        BSET   = 5'd11,
        BCLR   = 5'd12,
        BINV   = 5'd13,
        BSEL   = 5'd14,
        LDC    = 5'd15,
        // Compares write an all-ones or all-zero mask
        BGT    = 5'd16,
        BLE    = 5'd17,
        BEQ    = 5'd18,
        BNE    = 5'd19
    } opcode_t;

endpackage

`default_nettype wire

// ==== exec_core.f ====
+incdir+common
common/exec_isa_pkg.sv
common/exec_data_pkg.sv
rtl/exec_regfile.sv
rtl/exec_issue.sv
alu/exec_alu.sv
rtl/exec_writeback.sv
rtl/exec_core.sv
tests/exec_core_tb.sv

// ==== rtl/exec_core.sv ====
// Execute path top level. An instruction sampled at edge N writes its
// register at edge N+5; no forwarding, readers must wait six cycles.

`timescale 1ns/100ps
`default_nettype none

module exec_core (
    input  wire                           clock,
    input  wire                           rst_n,
    input  wire                           instr_valid,
    input  wire exec_isa_pkg::opcode_t    opcode,
    input  wire exec_data_pkg::reg_addr_t dest,
    input  wire exec_data_pkg::reg_addr_t src_a,
    input  wire exec_data_pkg::reg_addr_t src_b,
    input  wire exec_data_pkg::imm_t      imm,
    output logic                          result_valid,
    output exec_data_pkg::reg_addr_t      result_dest,
    output exec_data_pkg::data_t          result_data
);

    wire exec_data_pkg::reg_addr_t   read_addr_a;
    wire exec_data_pkg::reg_addr_t   read_addr_b;
    wire exec_data_pkg::data_t       read_data_a;
    wire exec_data_pkg::data_t       read_data_b;
    wire exec_data_pkg::issue_t      issue_word;
    wire exec_isa_pkg::opcode_t      issued_opcode;
    wire exec_data_pkg::alu_out_t    alu_word;
    wire exec_data_pkg::writeback_t  wb_word;

    exec_issue i_exec_issue (
        .clock        (clock),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .opcode       (opcode),
        .dest         (dest),
        .src_a        (src_a),
        .src_b        (src_b),
        .imm          (imm),
        .read_addr_a  (read_addr_a),
        .read_addr_b  (read_addr_b),
        .read_data_a  (read_data_a),
        .read_data_b  (read_data_b),
        .issue        (issue_word),
        .issued_opcode(issued_opcode)
    );

    // The write port is fed straight from writeback
    exec_regfile i_exec_regfile (
        .clock      (clock),
        .rst_n      (rst_n),
        .write_en   (wb_word.valid),
        .write_addr (wb_word.dest),
        .write_data (wb_word.data),
        .read_addr_a(read_addr_a),
        .read_addr_b(read_addr_b),
        .read_data_a(read_data_a),
        .read_data_b(read_data_b)
    );

    exec_alu i_exec_alu (
        .clock  (clock),
        .rst_n  (rst_n),
        .issue  (issue_word),
        .alu_out(alu_word)
    );

    exec_writeback i_exec_writeback (
        .clock        (clock),
        .rst_n        (rst_n),
        .issued_opcode(issued_opcode),
        .alu_out      (alu_word),
        .result       (wb_word)
    );

    assign result_valid = wb_word.valid;
    assign result_dest  = wb_word.dest;
    assign result_data  = wb_word.data;

endmodule

`default_nettype wire

// ==== rtl/exec_issue.sv ====
// Issue stage. Reads both operands in the cycle the instruction arrives and
// registers them; an instruction may arrive on every cycle.

`timescale 1ns/100ps
`default_nettype none

`include "exec_defs.svh"

module exec_issue (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire                         instr_valid,
    input  wire exec_isa_pkg::opcode_t  opcode,
    input  wire exec_data_pkg::reg_addr_t dest,
    input  wire exec_data_pkg::reg_addr_t src_a,
    input  wire exec_data_pkg::reg_addr_t src_b,
    input  wire exec_data_pkg::imm_t    imm,
    output exec_data_pkg::reg_addr_t    read_addr_a,
    output exec_data_pkg::reg_addr_t    read_addr_b,
    input  wire exec_data_pkg::data_t   read_data_a,
    input  wire exec_data_pkg::data_t   read_data_b,
    output exec_data_pkg::issue_t       issue,
    output exec_isa_pkg::opcode_t       issued_opcode
);

    exec_data_pkg::data_t imm_ext;
    exec_data_pkg::data_t operand_b_sel;

    assign read_addr_a = src_a;
    assign read_addr_b = src_b;

    // LDC takes its value from the instruction instead of a register
    assign imm_ext = {{(`EXEC_DATA_WIDTH - $bits(exec_data_pkg::imm_t)){imm[15]}}, imm};

    always_comb begin
        if (opcode == exec_isa_pkg::LDC) begin
            operand_b_sel = imm_ext;
        end else begin
            operand_b_sel = read_data_b;
        end
    end

    always_ff @(posedge clock) begin
        issue.opcode    <= opcode;
        issue.dest      <= dest;
        issue.operand_a <= read_data_a;
        issue.operand_b <= operand_b_sel;
        issue.imm       <= imm;
        if (!rst_n) begin
            issue.valid   <= 1'b0;
            issued_opcode <= exec_isa_pkg::NOP;
        end else begin
            issue.valid <= instr_valid;
            // Idle cycles enter the writeback delay line as NOP
            if (instr_valid) begin
                issued_opcode <= opcode;
            end else begin
                issued_opcode <= exec_isa_pkg::NOP;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exec_regfile.sv ====
// Register file with two asynchronous read ports and one clocked write port.
// A write is visible on the read ports from the cycle after its edge.

`timescale 1ns/100ps
`default_nettype none

`include "exec_defs.svh"

module exec_regfile (
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire                       write_en,
    input  wire exec_data_pkg::reg_addr_t write_addr,
    input  wire exec_data_pkg::data_t     write_data,
    input  wire exec_data_pkg::reg_addr_t read_addr_a,
    input  wire exec_data_pkg::reg_addr_t read_addr_b,
    output exec_data_pkg::data_t          read_data_a,
    output exec_data_pkg::data_t          read_data_b
);

    exec_data_pkg::data_t regs [`EXEC_REG_COUNT];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `EXEC_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    // No bypass, the program keeps writers and readers apart
    assign read_data_a = regs[read_addr_a];
    assign read_data_b = regs[read_addr_b];

    // A result from writeback must always name a real register
    write_addr_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        write_en |-> !$isunknown(write_addr)
    ) else $error("Register write with unknown address");

endmodule

`default_nettype wire

// ==== rtl/exec_writeback.sv ====
// Writeback stage. The opcode is delayed to line up with the ALU result;
// NOP and undefined opcodes never produce a result.

`timescale 1ns/100ps
`default_nettype none

`include "exec_defs.svh"

module exec_writeback (
    input  wire                           clock,
    input  wire                           rst_n,
    input  wire exec_isa_pkg::opcode_t    issued_opcode,
    input  wire exec_data_pkg::alu_out_t  alu_out,
    output exec_data_pkg::writeback_t     result
);

    exec_isa_pkg::opcode_t opcode_dly [`EXEC_ALU_DEPTH];

    logic                 keep;
    exec_data_pkg::data_t wb_data;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `EXEC_ALU_DEPTH; i++) begin
                opcode_dly[i] <= exec_isa_pkg::NOP;
            end
        end else begin
            opcode_dly[0] <= issued_opcode;
            for (int i = 1; i < `EXEC_ALU_DEPTH; i++) begin
                opcode_dly[i] <= opcode_dly[i-1];
            end
        end
    end

    always_comb begin
        keep    = 1'b1;
        wb_data = alu_out.data;
        case (opcode_dly[`EXEC_ALU_DEPTH-1])
            exec_isa_pkg::ADD, exec_isa_pkg::SUB, exec_isa_pkg::MUL,
            exec_isa_pkg::LAND, exec_isa_pkg::LOR, exec_isa_pkg::LNOT,
            exec_isa_pkg::SATP, exec_isa_pkg::SATN, exec_isa_pkg::ABS,
            exec_isa_pkg::POPCNT, exec_isa_pkg::BSET, exec_isa_pkg::BCLR,
            exec_isa_pkg::BINV, exec_isa_pkg::BSEL, exec_isa_pkg::LDC: begin
                keep = 1'b1;
            end
            exec_isa_pkg::BGT, exec_isa_pkg::BLE, exec_isa_pkg::BEQ, exec_isa_pkg::BNE: begin
                // Any set bit in the low byte counts as true
                wb_data = (|alu_out.data[7:0]) ? '1 : '0;
            end
            default: begin
                keep = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        result.dest <= alu_out.dest;
        result.data <= wb_data;
        if (!rst_n) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= alu_out.valid && keep;
        end
    end

    // Nothing left in the pipeline may leak out right after reset
    quiet_after_reset: assert property (
        @(posedge clock)
        $rose(rst_n) |-> !result.valid ##1 !result.valid
    ) else $error("Result valid raised right after reset");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the execute path testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --top-module exec_core_tb -Mdir obj_dir -f exec_core.f

status=0
./obj_dir/Vexec_core_tb > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -qF '*** TEST FAILED ***' "$LOG" || [ "$status" -ne 0 ]; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
echo "Simulation finished without failures"

// ==== tests/exec_core_tb.sv ====
// Testbench for the execute path. Run it from the project root, it reads
// tests/exec_stimulus.txt, whose program keeps six cycles between a write
// and the next read of the same register.

`timescale 1ns/100ps
`default_nettype none

module exec_core_tb;

    // The counter value seen at the falling edge that shows a result,
    // counted from the value read at the edge that drives the instruction
    localparam int RESULT_OFFSET = 6;
    localparam int RESET_CYCLES  = 16;
    localparam int DRAIN_LIMIT   = 50;

    typedef struct packed {
        logic [4:0]               opcode;
        exec_data_pkg::reg_addr_t dest;
        exec_data_pkg::reg_addr_t src_a;
        exec_data_pkg::reg_addr_t src_b;
        exec_data_pkg::imm_t      imm;
    } instr_t;

    typedef struct packed {
        int                       cycle;
        int                       line_no;
        logic                     valid;
        exec_data_pkg::reg_addr_t dest;
        exec_data_pkg::data_t     data;
    } exp_item_t;

    logic                     clock = 1'b0;
    logic                     rst_n;
    logic                     instr_valid;
    exec_isa_pkg::opcode_t    opcode;
    exec_data_pkg::reg_addr_t dest;
    exec_data_pkg::reg_addr_t src_a;
    exec_data_pkg::reg_addr_t src_b;
    exec_data_pkg::imm_t      imm;
    logic                     result_valid;
    exec_data_pkg::reg_addr_t result_dest;
    exec_data_pkg::data_t     result_data;

    int        cyc = 0;
    int        errors = 0;
    int        checks = 0;
    exp_item_t exp_q[$];

    exec_core i_exec_core (
        .clock       (clock),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .opcode      (opcode),
        .dest        (dest),
        .src_a       (src_a),
        .src_b       (src_b),
        .imm         (imm),
        .result_valid(result_valid),
        .result_dest (result_dest),
        .result_data (result_data)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cyc <= cyc + 1;
    end

    // Outputs are sampled on the falling edge, away from the register updates
    always @(negedge clock) begin : check_results
        exp_item_t item;
        if (exp_q.size() > 0 && exp_q[0].cycle == cyc) begin
            item = exp_q.pop_front();
            checks++;
            if (item.valid) begin
                assert (result_valid === 1'b1) else begin
                    $display("No result for stimulus line %0d in cycle %0d", item.line_no, cyc);
                    errors++;
                end
                if (result_valid === 1'b1) begin
                    assert (result_dest === item.dest) else begin
                        $display("Fail result_dest: got %h, expected %h (line %0d)",
                                 result_dest, item.dest, item.line_no);
                        errors++;
                    end
                    assert (result_data === item.data) else begin
                        $display("Fail result_data: got %h, expected %h (line %0d)",
                                 result_data, item.data, item.line_no);
                        errors++;
                    end
                end
            end else begin
                assert (result_valid === 1'b0) else begin
                    $display("Dropped instruction on line %0d still gave a result", item.line_no);
                    errors++;
                end
            end
        end else begin
            assert (result_valid === 1'b0) else begin
                $display("Unexpected result in cycle %0d with no instruction due", cyc);
                errors++;
            end
        end
    end

    task automatic drive_instr(input instr_t instr, input logic exp_valid,
                               input exec_data_pkg::data_t exp_data, input int line_no);
        exp_item_t item;
        @(posedge clock);
        instr_valid <= 1'b1;
        opcode      <= exec_isa_pkg::opcode_t'(instr.opcode);
        dest        <= instr.dest;
        src_a       <= instr.src_a;
        src_b       <= instr.src_b;
        imm         <= instr.imm;
        item.cycle   = cyc + RESULT_OFFSET;
        item.line_no = line_no;
        item.valid   = exp_valid;
        item.dest    = instr.dest;
        item.data    = exp_data;
        exp_q.push_back(item);
    endtask

    task automatic idle_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clock);
            instr_valid <= 1'b0;
        end
    endtask

    initial begin : run
        int                       fd;
        int                       n;
        int                       line_no;
        int                       gap;
        int                       drain;
        string                    line;
        logic [4:0]               op_word;
        exec_data_pkg::reg_addr_t d;
        exec_data_pkg::reg_addr_t sa;
        exec_data_pkg::reg_addr_t sb;
        exec_data_pkg::imm_t      im;
        logic                     ev;
        exec_data_pkg::data_t     ed;

        rst_n       = 1'b0;
        instr_valid = 1'b0;
        opcode      = exec_isa_pkg::NOP;
        dest        = '0;
        src_a       = '0;
        src_b       = '0;
        imm         = '0;
        line_no     = 0;

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clock);
        end
        rst_n <= 1'b1;
        idle_cycles(4);

        fd = $fopen("tests/exec_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/exec_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                line_no++;
                if (n > 0 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                op_word, d, sa, sb, im, gap, ev, ed);
                    if (n == 8) begin
                        drive_instr('{op_word, d, sa, sb, im}, ev, ed, line_no);
                        idle_cycles(gap);
                    end else if (n > 0) begin
                        $display("Malformed stimulus line %0d", line_no);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        idle_cycles(1);

        drain = 0;
        while (exp_q.size() > 0 && drain < DRAIN_LIMIT) begin
            @(posedge clock);
            drain++;
        end
        if (exp_q.size() > 0) begin
            $display("Timed out with %0d results still outstanding", exp_q.size());
            errors++;
        end
        // Quiet cycles at the end catch stray pulses after the last result
        idle_cycles(8);

        $display("Checked %0d results, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/exec_stimulus.txt ====
# opcode dest src_a src_b imm gap exp_valid exp_data, all fields in hex
# gap is the number of idle cycles after the instruction, exp_data the value written to dest
0f 1 0 0 1234 0 1 00001234
0f 2 0 0 fff0 0 1 fffffff0
0f 3 0 0 7fff 1 1 00007fff
0f 4 0 0 8001 0 1 ffff8001
0f 5 0 0 0005 2 1 00000005
0f 6 0 0 0012 5 1 00000012
01 7 1 2 0000 0 1 00001224
02 8 3 4 0000 0 1 0000fffe
03 9 4 2 0000 0 1 0007fff0
03 a 3 3 0000 0 1 3fff0001
01 b 4 4 0000 5 1 ffff0002
04 c 1 3 0000 0 1 00001234
05 d 1 2 0000 0 1 fffffff4
06 e 1 0 0000 0 1 ffffedcb
09 f 4 0 0000 0 1 00007fff
09 c 1 0 0000 0 1 00001234
0a d 4 0 0000 0 1 00000012
07 e 2 5 0000 0 1 fffffff0
08 f 2 5 0000 0 1 00000005
0b c 1 6 0000 0 1 00041234
0b d 1 2 0000 0 1 00011234
0c e 1 5 0000 0 1 00001214
0d f 2 5 0000 0 1 ffffffd0
0e c 1 5 0000 0 1 00000001
0e d 1 6 0000 5 1 00000000
10 7 1 2 0000 0 1 ffffffff
10 8 2 1 0000 0 1 00000000
10 7 4 2 0000 0 1 00000000
11 9 4 2 0000 0 1 ffffffff
11 a 3 1 0000 0 1 00000000
11 b 5 5 0000 0 1 ffffffff
12 c 4 4 0000 0 1 ffffffff
12 d 2 4 0000 0 1 00000000
13 e 2 4 0000 0 1 ffffffff
13 f 6 6 0000 5 1 00000000
01 8 5 6 0000 0 1 00000017
00 9 0 0 0000 0 0 00000000
15 a 1 2 0000 0 0 00000000
02 b 6 5 0000 0 1 0000000d
1f c 3 4 0000 0 0 00000000
03 d 5 6 0000 5 1 0000005a
0f 5 0 0 ffff 5 1 ffffffff
01 e 5 1 0000 5 1 00001233
